/* dv/psx_loader_tb.sv */
`timescale 1ns/1ns

module psx_loader_tb;

	// Over twenty times the cycles that all tests together take
	localparam int TIMEOUT_CYCLES = 20000;

	logic                              clk_1x;
	logic                              reset;
	logic                              download;
	logic                              dl_valid;
	psx_loader_pkg::dl_word_t          dl_word;
	logic                              dl_ready;
	logic                              ram_valid;
	psx_loader_pkg::ram_req_t          ram_req;
	logic                              ram_ready;
	psx_loader_pkg::exe_header_t       exe_header;
	logic                              load_exe;
	logic [2:0]                        sd_ack;
	logic                              sd_byte_wr;
	logic [7:0]                        sd_byte;
	psx_loader_pkg::sd_baddr_t         sd_byte_addr;
	logic                              sd_word_valid;
	psx_loader_pkg::sd_word_t          sd_word;
	logic [2:0]                        img_mounted;
	logic [31:0]                       img_size;
	logic [1:0]                        st_region;
	psx_loader_pkg::region_t           detected_region;
	logic                              has_cd;
	psx_loader_pkg::region_t           region;
	logic                              is_pal;
	psx_loader_pkg::region_t           bios_region;
	logic [1:0]                        card_mounted;
	logic [1:0]                        card_inserted;
	logic [1:0]                        card_load;

	integer                            seed;
	int                                assert_errors;
	int                                check_errors;
	int                                exe_pulses;
	string                             test_name;
	logic                              cd_bios_done;
	logic [255:0]                      ready_pattern;
	logic [7:0]                        ready_idx;
	psx_loader_pkg::ram_req_t          ram_exp_q[$];
	psx_loader_pkg::ram_req_t          ram_exp;
	psx_loader_pkg::sd_word_t          sd_exp_q[$];
	psx_loader_pkg::sd_word_t          sd_exp;
	psx_loader_pkg::exe_header_t       hdr_exp;
	logic                              sd_hi_next;
	logic [7:0]                        sd_lo;
	logic [2:0]                        sd_prev_ack;
	psx_loader_pkg::sd_baddr_t         sd_addr_cnt;
	// Per slot, mounted with a nonzero image and settled
	logic [1:0]                        card_mount_exp;

	psx_loader_top #(
		.MEMCARD_DELAY_BITS (6)
	) dut_i (.*);

	initial begin
		clk_1x = 1'b0;
		forever #5 clk_1x = ~clk_1x;
	end

	// Memory side acceptance follows a fixed random pattern
	initial begin
		ram_ready = 1'b0;
		ready_idx = 8'd0;
		forever begin
			@(posedge clk_1x);
			#1;
			ram_ready = ready_pattern[ready_idx];
			ready_idx = ready_idx + 8'd1;
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk_1x);
		$display("ERROR: watchdog expired after %0d cycles, a handshake never completed",
			TIMEOUT_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	// ========================================
	// Checks
	// ========================================
	task automatic flag_assert(input string msg);
		assert_errors++;
		$display("ERROR: %s (test %s, time %0t)", msg, test_name, $time);
	endtask

	task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
		assert (exp == act) else begin
			check_errors++;
			$display("CHECK FAILED %s %s expected %0h actual %0h", test_name, what, exp, act);
		end
	endtask

	ready_low_a: assert property (@(posedge clk_1x) disable iff (reset)
		ram_valid |-> !dl_ready) else flag_assert("dl_ready high while a write waits");
	write_hold_a: assert property (@(posedge clk_1x) disable iff (reset)
		ram_valid && !ram_ready |=> ram_valid && $stable(ram_req))
		else flag_assert("pending memory write changed or dropped");
	pal_a: assert property (@(posedge clk_1x) disable iff (reset)
		is_pal == (region == 2'd2)) else flag_assert("is_pal disagrees with region");
	exe_pulse_a: assert property (@(posedge clk_1x) disable iff (reset)
		load_exe |=> !load_exe) else flag_assert("load_exe longer than one cycle");
	sd_pulse_a: assert property (@(posedge clk_1x) disable iff (reset)
		sd_word_valid |=> !sd_word_valid) else flag_assert("sd_word_valid held two cycles");
	card_ins_a: assert property (@(posedge clk_1x) disable iff (reset)
		(card_inserted & ~card_mounted) == 2'b00) else flag_assert("card inserted not mounted");
	card_load0_a: assert property (@(posedge clk_1x) disable iff (reset)
		card_load[0] |=> !card_load[0]) else flag_assert("slot 0 load pulse too long");
	card_load1_a: assert property (@(posedge clk_1x) disable iff (reset)
		card_load[1] |=> !card_load[1]) else flag_assert("slot 1 load pulse too long");

	// Scoreboards for memory writes and SD words
	always @(posedge clk_1x) begin
		if (!reset && ram_valid && ram_ready) begin
			if (ram_exp_q.size() == 0) begin
				flag_assert("memory write issued with none expected");
			end else begin
				ram_exp = ram_exp_q.pop_front();
				compare("ram_req", 64'(ram_exp), 64'(ram_req));
			end
		end
		if (!reset && sd_word_valid) begin
			if (sd_exp_q.size() == 0) begin
				flag_assert("SD word issued without a byte pair");
			end else begin
				sd_exp = sd_exp_q.pop_front();
				compare("sd_word", 64'(sd_exp), 64'(sd_word));
			end
		end
		if (!reset && load_exe)
			exe_pulses++;
	end

	// ========================================
	// Stimulus helpers
	// ========================================
	task automatic step();
		@(posedge clk_1x);
		#1;
	endtask

	function automatic psx_loader_pkg::ram_addr_t map_addr(input psx_loader_pkg::dl_kind_e kind,
			input psx_loader_pkg::ram_addr_t ofs);
		if (kind == psx_loader_pkg::DL_EXE)
			return psx_loader_pkg::EXE_START + {4'd0, ofs[22:0]};
		return psx_loader_pkg::BIOS_START + {6'd0, ofs[20:0]};
	endfunction

	// Forced settings count from 1, auto follows the disc code
	function automatic psx_loader_pkg::region_t expected_region(input logic [1:0] st,
			input psx_loader_pkg::region_t det);
		if (st != 2'd0)
			return st - 2'd1;
		if (det == 2'd1)
			return 2'd1;
		if (det == 2'd3)
			return 2'd2;
		return 2'd0;
	endfunction

	task automatic send_half(input psx_loader_pkg::ram_addr_t addr,
			input psx_loader_pkg::half_t data);
		logic taken;
		dl_valid = 1'b1;
		dl_word.addr = addr;
		dl_word.data = data;
		taken = 1'b0;
		while (!taken) begin
			taken = dl_ready;
			step();
		end
	endtask

	task automatic send_pair(input psx_loader_pkg::dl_kind_e kind,
			input psx_loader_pkg::ram_addr_t ofs, input psx_loader_pkg::ram_data_t data);
		psx_loader_pkg::ram_req_t exp;
		exp.kind = kind;
		exp.addr = map_addr(kind, ofs);
		exp.data = data;
		ram_exp_q.push_back(exp);
		send_half(ofs, data[15:0]);
		send_half(ofs | 27'd2, data[31:16]);
	endtask

	task automatic start_download(input psx_loader_pkg::dl_index_t idx);
		download = 1'b1;
		dl_word.index = idx;
		step();
	endtask

	task automatic wait_drain();
		dl_valid = 1'b0;
		while (ram_exp_q.size() != 0)
			step();
	endtask

	task automatic bios_download(input psx_loader_pkg::dl_index_t idx,
			input psx_loader_pkg::dl_kind_e kind, input psx_loader_pkg::ram_addr_t base);
		start_download(idx);
		for (int k = 0; k < 12; k++)
			send_pair(kind, base + 27'(k * 4), $random(seed));
		wait_drain();
		download = 1'b0;
		repeat (2) step();
	endtask

	task automatic exe_download();
		psx_loader_pkg::ram_data_t word;
		int pulses_before;
		start_download(psx_loader_pkg::EXE_INDEX);
		for (int w = 0; w < 20; w++) begin
			word = $random(seed);
			// Header words sit at byte offsets 0x10 to 0x1C and 0x30, 0x34
			if (w == 4)
				hdr_exp.pc = word;
			if (w == 5)
				hdr_exp.gp = word;
			if (w == 6)
				hdr_exp.load_addr = word;
			if (w == 7)
				hdr_exp.file_size = word;
			if (w == 12)
				hdr_exp.stack_ptr = word;
			if (w == 13)
				hdr_exp.stack_ptr = hdr_exp.stack_ptr + word;
			send_pair(psx_loader_pkg::DL_EXE, 27'(w * 4), word);
		end
		wait_drain();
		download = 1'b0;
		pulses_before = exe_pulses;
		step();
		compare("load_exe one cycle after end", 64'd0, 64'(load_exe));
		step();
		compare("load_exe two cycles after end", 64'd1, 64'(load_exe));
		repeat (3) step();
		compare("load_exe pulse count", 64'd1, 64'(exe_pulses - pulses_before));
		compare("pc", 64'(hdr_exp.pc), 64'(exe_header.pc));
		compare("gp", 64'(hdr_exp.gp), 64'(exe_header.gp));
		compare("load_addr", 64'(hdr_exp.load_addr), 64'(exe_header.load_addr));
		compare("file_size", 64'(hdr_exp.file_size), 64'(exe_header.file_size));
		compare("stack_ptr", 64'(hdr_exp.stack_ptr), 64'(exe_header.stack_ptr));
	endtask

	task automatic sweep_regions();
		psx_loader_pkg::region_t exp;
		for (int s = 0; s < 4; s++) begin
			for (int d = 0; d < 4; d++) begin
				st_region = 2'(s);
				detected_region = 2'(d);
				step();
				exp = expected_region(2'(s), 2'(d));
				compare("region", 64'(exp), 64'(region));
				compare("is_pal", 64'(exp == 2'd2), 64'(is_pal));
				compare("bios_region", cd_bios_done ? 64'd3 : 64'(exp), 64'(bios_region));
			end
		end
	endtask

	task automatic mount_card(input logic slot, input logic [31:0] size);
		int waited;
		logic other;
		other = !slot;
		img_mounted = slot ? 3'b100 : 3'b010;
		img_size = size;
		step();
		img_mounted = 3'd0;
		compare("card load", 64'(size != 32'd0), 64'(card_load[slot]));
		compare("card mounted", 64'(size != 32'd0), 64'(card_mounted[slot]));
		compare("card inserted at mount", 64'd0, 64'(card_inserted[slot]));
		compare("other slot load", 64'd0, 64'(card_load[other]));
		waited = 0;
		while (!card_inserted[slot] && waited < 40) begin
			step();
			waited++;
		end
		if (size != 32'd0) begin
			assert (waited >= 32 && waited <= 36) else begin
				check_errors++;
				$display("CHECK FAILED %s insert delay expected 32 to 36 actual %0d",
					test_name, waited);
			end
		end else begin
			compare("card inserted after empty mount", 64'd0, 64'(card_inserted[slot]));
		end
		// A settled mounted slot has long passed its insertion delay
		compare("other slot mounted", 64'(card_mount_exp[other]), 64'(card_mounted[other]));
		compare("other slot inserted", 64'(card_mount_exp[other]), 64'(card_inserted[other]));
		card_mount_exp[slot] = size != 32'd0;
	endtask

	task automatic sd_stream(input int count);
		logic rise;
		logic hi;
		psx_loader_pkg::sd_word_t exp;
		for (int k = 0; k < count; k++) begin
			// Now and then a new transfer on a random channel
			if (k % 11 == 7)
				sd_ack = 3'($random(seed));
			rise = |(sd_ack & ~sd_prev_ack);
			sd_prev_ack = sd_ack;
			sd_byte_wr = ($random(seed) & 3) != 0;
			sd_byte = 8'($random(seed));
			sd_byte_addr = sd_addr_cnt;
			hi = sd_hi_next && !rise;
			if (sd_byte_wr) begin
				if (hi) begin
					exp.addr = 9'(sd_addr_cnt >> 1);
					exp.data = {sd_byte, sd_lo};
					sd_exp_q.push_back(exp);
				end else begin
					sd_lo = sd_byte;
				end
				sd_hi_next = !hi;
				sd_addr_cnt = sd_addr_cnt + 10'd1;
			end else if (rise) begin
				sd_hi_next = 1'b0;
			end
			step();
		end
		sd_byte_wr = 1'b0;
		repeat (3) step();
		compare("sd words outstanding", 64'd0, 64'(sd_exp_q.size()));
	endtask

	task automatic mount_cd(input logic [31:0] size);
		img_mounted = 3'b001;
		img_size = size;
		step();
		img_mounted = 3'd0;
		compare("has_cd", 64'(size != 32'd0), 64'(has_cd));
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		seed = 32'h6e48_34ea;
		assert_errors = 0;
		check_errors = 0;
		exe_pulses = 0;
		test_name = "reset";
		cd_bios_done = 1'b0;
		card_mount_exp = 2'b00;
		repeat (256)
			ready_pattern = {ready_pattern[254:0], 1'($random(seed))};
		reset = 1'b1;
		download = 1'b0;
		dl_valid = 1'b0;
		dl_word = '0;
		sd_ack = 3'd0;
		sd_byte_wr = 1'b0;
		sd_byte = 8'd0;
		sd_byte_addr = '0;
		img_mounted = 3'd0;
		img_size = 32'd0;
		st_region = 2'd0;
		detected_region = 2'd0;
		sd_hi_next = 1'b0;
		sd_lo = 8'd0;
		sd_prev_ack = 3'd0;
		sd_addr_cnt = '0;
		repeat (10) @(posedge clk_1x);
		#1;
		reset = 1'b0;
		step();

		test_name = "bios download";
		bios_download(8'h00, psx_loader_pkg::DL_BIOS, 27'h0a0_0100);
		test_name = "region before cd-bios";
		sweep_regions();
		test_name = "cd-bios download";
		bios_download(8'hc0, psx_loader_pkg::DL_CD_BIOS, 27'h01f_ffe0);
		cd_bios_done = 1'b1;
		test_name = "region after cd-bios";
		sweep_regions();
		test_name = "exe download";
		exe_download();

		test_name = "memory cards";
		mount_card(1'b0, 32'h0002_0000);
		mount_card(1'b1, 32'h0002_0000);
		mount_card(1'b0, 32'd0);
		mount_card(1'b1, 32'd0);

		test_name = "sd packing";
		sd_stream(300);

		test_name = "cd presence";
		mount_cd(32'h1234_5000);
		mount_cd(32'd0);
		mount_cd(32'h0000_0800);

		test_name = "final";
		compare("load_exe total pulses", 64'd1, 64'(exe_pulses));
		$display("Errors: %0d assertion failures, %0d value check failures",
			assert_errors, check_errors);
		if (assert_errors == 0 && check_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* psx_loader.f */
rtl/psx_loader_pkg.sv
rtl/download_packer.sv
rtl/exe_header_capture.sv
rtl/media_status.sv
rtl/memcard_slot.sv
rtl/sd_word_packer.sv
rtl/psx_loader_top.sv
dv/psx_loader_tb.sv

/* rtl/download_packer.sv */
`timescale 1ns/1ns

module download_packer (
	input  logic                      clk_1x,
	input  logic                      reset,
	input  logic                      download,
	input  logic                      dl_valid,
	input  psx_loader_pkg::dl_word_t  dl_word,
	input  logic                      ram_ready,
	output logic                      dl_ready,
	output logic                      ram_valid,
	output psx_loader_pkg::ram_req_t  ram_req,
	output psx_loader_pkg::dl_kind_e  dl_kind
);

	logic                       word_take;
	logic                       index_is_bios;
	psx_loader_pkg::ram_addr_t  mapped_addr;
	psx_loader_pkg::ram_addr_t  lo_addr;
	psx_loader_pkg::half_t      lo_data;

	assign index_is_bios = (dl_word.index[5:0] & psx_loader_pkg::BIOS_INDEX_MASK) == 6'd0;

	// Words of an unknown download are consumed and dropped
	assign word_take = dl_valid && dl_ready && (dl_kind != psx_loader_pkg::DL_NONE);

	// ========================================
	// Download kind decode
	// ========================================
	always_ff @(posedge clk_1x) begin
		if (reset) begin
			dl_kind <= psx_loader_pkg::DL_NONE;
		end else if (!download) begin
			dl_kind <= psx_loader_pkg::DL_NONE;
		end else if (index_is_bios) begin
			// Top index bits 11 select the CD-BIOS image
			if (dl_word.index[7:6] == 2'b11)
				dl_kind <= psx_loader_pkg::DL_CD_BIOS;
			else
				dl_kind <= psx_loader_pkg::DL_BIOS;
		end else if (dl_word.index == psx_loader_pkg::EXE_INDEX) begin
			dl_kind <= psx_loader_pkg::DL_EXE;
		end else begin
			dl_kind <= psx_loader_pkg::DL_NONE;
		end
	end

	always_comb begin
		if (dl_kind == psx_loader_pkg::DL_EXE)
			mapped_addr = psx_loader_pkg::EXE_START + {4'd0, dl_word.addr[22:0]};
		else
			mapped_addr = psx_loader_pkg::BIOS_START + {6'd0, dl_word.addr[20:0]};
	end

	// ========================================
	// Halfword pairing
	// ========================================
	always_ff @(posedge clk_1x) begin
		if (word_take && !dl_word.addr[1]) begin
			lo_addr <= mapped_addr;
			lo_data <= dl_word.data;
		end
		if (word_take && dl_word.addr[1]) begin
			ram_req.kind <= dl_kind;
			ram_req.addr <= lo_addr;
			ram_req.data <= {dl_word.data, lo_data};
		end
	end

	// One write in flight, source held off until it is taken
	always_ff @(posedge clk_1x) begin
		if (reset) begin
			dl_ready  <= 1'b0;
			ram_valid <= 1'b0;
		end else if (ram_valid) begin
			if (ram_ready) begin
				ram_valid <= 1'b0;
				dl_ready  <= 1'b1;
			end
		end else if (word_take && dl_word.addr[1]) begin
			ram_valid <= 1'b1;
			dl_ready  <= 1'b0;
		end else begin
			dl_ready <= 1'b1;
		end
	end

	stable_req_a: assert property (@(posedge clk_1x) disable iff (reset)
		ram_valid && !ram_ready |=> ram_valid && $stable(ram_req));

endmodule

/* rtl/exe_header_capture.sv */
`timescale 1ns/1ns

module exe_header_capture (
	input  logic                          clk_1x,
	input  logic                          reset,
	input  logic                          ram_valid,
	input  logic                          ram_ready,
	input  psx_loader_pkg::ram_req_t      ram_req,
	input  psx_loader_pkg::dl_kind_e      dl_kind,
	output psx_loader_pkg::exe_header_t   exe_header,
	output logic                          load_exe
);

	logic                       exe_write;
	logic                       exe_active_q;
	psx_loader_pkg::ram_addr_t  hdr_ofs;

	assign exe_write = ram_valid && ram_ready && (ram_req.kind == psx_loader_pkg::DL_EXE);
	assign hdr_ofs   = ram_req.addr - psx_loader_pkg::EXE_START;

	// Header words snooped off the memory write port
	always_ff @(posedge clk_1x) begin
		if (exe_write) begin
			case (hdr_ofs)
				psx_loader_pkg::HDR_PC:      exe_header.pc        <= ram_req.data;
				psx_loader_pkg::HDR_GP:      exe_header.gp        <= ram_req.data;
				psx_loader_pkg::HDR_LOAD:    exe_header.load_addr <= ram_req.data;
				psx_loader_pkg::HDR_SIZE:    exe_header.file_size <= ram_req.data;
				psx_loader_pkg::HDR_SP_BASE: exe_header.stack_ptr <= ram_req.data;
				// Offset word follows the base and is added on top
				psx_loader_pkg::HDR_SP_OFS: begin
					exe_header.stack_ptr <= exe_header.stack_ptr + ram_req.data;
				end
				default: begin
				end
			endcase
		end
	end

	// Start pulse on the end of an executable download
	always_ff @(posedge clk_1x) begin
		if (reset) begin
			exe_active_q <= 1'b0;
			load_exe     <= 1'b0;
		end else begin
			exe_active_q <= dl_kind == psx_loader_pkg::DL_EXE;
			load_exe     <= exe_active_q && (dl_kind != psx_loader_pkg::DL_EXE);
		end
	end

	load_single_a: assert property (@(posedge clk_1x) disable iff (reset)
		load_exe |=> !load_exe);

endmodule

/* rtl/media_status.sv */
`timescale 1ns/1ns

module media_status (
	input  logic                      clk_1x,
	input  logic                      reset,
	input  logic                      cd_mounted,
	input  logic [31:0]               img_size,
	input  logic [1:0]                st_region,
	input  psx_loader_pkg::region_t   detected_region,
	input  psx_loader_pkg::dl_kind_e  dl_kind,
	output logic                      has_cd,
	output psx_loader_pkg::region_t   region,
	output logic                      is_pal,
	output psx_loader_pkg::region_t   bios_region
);

	psx_loader_pkg::region_t region_next;
	logic                    cd_bios_seen;
	logic                    cd_bios_now;

	assign cd_bios_now = cd_bios_seen || (dl_kind == psx_loader_pkg::DL_CD_BIOS);

	// Auto mode follows the disc, otherwise the menu forces it
	always_comb begin
		if (st_region == 2'd0) begin
			case (detected_region)
				2'd1:    region_next = psx_loader_pkg::REGION_NTSC_J;
				2'd3:    region_next = psx_loader_pkg::REGION_PAL;
				default: region_next = psx_loader_pkg::REGION_NTSC_U;
			endcase
		end else begin
			region_next = st_region - 2'd1;
		end
	end

	always_ff @(posedge clk_1x) begin
		if (reset) begin
			has_cd       <= 1'b0;
			cd_bios_seen <= 1'b0;
			region       <= psx_loader_pkg::REGION_NTSC_U;
			is_pal       <= 1'b0;
			bios_region  <= psx_loader_pkg::REGION_NTSC_U;
		end else begin
			if (cd_mounted)
				has_cd <= img_size != 32'd0;
			cd_bios_seen <= cd_bios_now;
			region       <= region_next;
			is_pal       <= region_next == psx_loader_pkg::REGION_PAL;
			bios_region  <= cd_bios_now ? psx_loader_pkg::REGION_CD_BIOS : region_next;
		end
	end

endmodule

/* rtl/memcard_slot.sv */
`timescale 1ns/1ns

module memcard_slot #(
	parameter int DELAY_BITS = 26
) (
	input  logic        clk_1x,
	input  logic        reset,
	input  logic        card_mounted,
	input  logic [31:0] img_size,
	output logic        mounted,
	output logic        inserted,
	output logic        load
);

	logic [DELAY_BITS-1:0] delay_cnt;

	// Card stays out for a while after a change so the console
	// notices the swap
	always_ff @(posedge clk_1x) begin
		if (reset) begin
			mounted   <= 1'b0;
			inserted  <= 1'b0;
			load      <= 1'b0;
			delay_cnt <= '0;
		end else begin
			load <= 1'b0;
			if (card_mounted) begin
				inserted  <= 1'b0;
				delay_cnt <= '0;
				if (img_size != 32'd0) begin
					mounted <= 1'b1;
					load    <= 1'b1;
				end else begin
					mounted <= 1'b0;
				end
			end else if (mounted) begin
				// Counter stops once the top bit is reached
				if (delay_cnt[DELAY_BITS-1])
					inserted <= 1'b1;
				else
					delay_cnt <= delay_cnt + 1'b1;
			end
		end
	end

	inserted_mounted_a: assert property (@(posedge clk_1x) disable iff (reset)
		inserted |-> mounted);

endmodule

/* rtl/psx_loader_pkg.sv */
package psx_loader_pkg;

	// ========================================
	// Widths
	// ========================================
	typedef logic [26:0] ram_addr_t;
	typedef logic [31:0] ram_data_t;
	typedef logic [15:0] half_t;
	typedef logic [7:0]  dl_index_t;
	typedef logic [8:0]  sd_waddr_t;
	typedef logic [9:0]  sd_baddr_t;
	typedef logic [1:0]  region_t;

	// Memory map of downloaded images
	localparam ram_addr_t BIOS_START = 27'd8388608;
	localparam ram_addr_t EXE_START  = 27'd16777216;

	// Executable header offsets from the image start
	localparam ram_addr_t HDR_PC      = 27'h10;
	localparam ram_addr_t HDR_GP      = 27'h14;
	localparam ram_addr_t HDR_LOAD    = 27'h18;
	localparam ram_addr_t HDR_SIZE    = 27'h1C;
	localparam ram_addr_t HDR_SP_BASE = 27'h30;
	localparam ram_addr_t HDR_SP_OFS  = 27'h34;

	// Host download indices
	localparam dl_index_t  EXE_INDEX       = 8'd1;
	localparam logic [5:0] BIOS_INDEX_MASK = 6'h3f;

	// Region codes
	localparam region_t REGION_NTSC_U  = 2'd0;
	localparam region_t REGION_NTSC_J  = 2'd1;
	localparam region_t REGION_PAL     = 2'd2;
	localparam region_t REGION_CD_BIOS = 2'd3;

	typedef enum logic [1:0] {
		DL_NONE,
		DL_BIOS,
		DL_CD_BIOS,
		DL_EXE
	} dl_kind_e;

	// ========================================
	// Port bundles
	// ========================================
	typedef struct packed {
		dl_index_t index;
		ram_addr_t addr;
		half_t     data;
	} dl_word_t;

	typedef struct packed {
		dl_kind_e  kind;
		ram_addr_t addr;
		ram_data_t data;
	} ram_req_t;

	typedef struct packed {
		ram_data_t pc;
		ram_data_t gp;
		ram_data_t load_addr;
		ram_data_t file_size;
		ram_data_t stack_ptr;
	} exe_header_t;

	typedef struct packed {
		sd_waddr_t addr;
		half_t     data;
	} sd_word_t;

endpackage

/* rtl/psx_loader_top.sv */
`timescale 1ns/1ns

module psx_loader_top #(
	parameter int MEMCARD_DELAY_BITS = 26
) (
	input  logic                           clk_1x,
	input  logic                           reset,
	// Host file download
	input  logic                           download,
	input  logic                           dl_valid,
	input  psx_loader_pkg::dl_word_t       dl_word,
	output logic                           dl_ready,
	// Memory write port
	output logic                           ram_valid,
	output psx_loader_pkg::ram_req_t       ram_req,
	input  logic                           ram_ready,
	output psx_loader_pkg::exe_header_t    exe_header,
	output logic                           load_exe,
	// SD buffer stream
	input  logic [2:0]                     sd_ack,
	input  logic                           sd_byte_wr,
	input  logic [7:0]                     sd_byte,
	input  psx_loader_pkg::sd_baddr_t      sd_byte_addr,
	output logic                           sd_word_valid,
	output psx_loader_pkg::sd_word_t       sd_word,
	// Image mounts and status
	input  logic [2:0]                     img_mounted,
	input  logic [31:0]                    img_size,
	input  logic [1:0]                     st_region,
	input  psx_loader_pkg::region_t        detected_region,
	output logic                           has_cd,
	output psx_loader_pkg::region_t        region,
	output logic                           is_pal,
	output psx_loader_pkg::region_t        bios_region,
	output logic [1:0]                     card_mounted,
	output logic [1:0]                     card_inserted,
	output logic [1:0]                     card_load
);

	psx_loader_pkg::dl_kind_e dl_kind;

	download_packer download_packer_i (
		.clk_1x    (clk_1x),
		.reset     (reset),
		.download  (download),
		.dl_valid  (dl_valid),
		.dl_word   (dl_word),
		.ram_ready (ram_ready),
		.dl_ready  (dl_ready),
		.ram_valid (ram_valid),
		.ram_req   (ram_req),
		.dl_kind   (dl_kind)
	);

	exe_header_capture exe_header_capture_i (
		.clk_1x     (clk_1x),
		.reset      (reset),
		.ram_valid  (ram_valid),
		.ram_ready  (ram_ready),
		.ram_req    (ram_req),
		.dl_kind    (dl_kind),
		.exe_header (exe_header),
		.load_exe   (load_exe)
	);

	// Slot 0 is the CD image, slots 1 and 2 the memory cards
	media_status media_status_i (
		.clk_1x          (clk_1x),
		.reset           (reset),
		.cd_mounted      (img_mounted[0]),
		.img_size        (img_size),
		.st_region       (st_region),
		.detected_region (detected_region),
		.dl_kind         (dl_kind),
		.has_cd          (has_cd),
		.region          (region),
		.is_pal          (is_pal),
		.bios_region     (bios_region)
	);

	for (genvar i = 0; i < 2; i++) begin : g_card
		memcard_slot #(
			.DELAY_BITS (MEMCARD_DELAY_BITS)
		) memcard_slot_i (
			.clk_1x       (clk_1x),
			.reset        (reset),
			.card_mounted (img_mounted[i+1]),
			.img_size     (img_size),
			.mounted      (card_mounted[i]),
			.inserted     (card_inserted[i]),
			.load         (card_load[i])
		);
	end

	sd_word_packer sd_word_packer_i (
		.clk_1x        (clk_1x),
		.reset         (reset),
		.sd_ack        (sd_ack),
		.sd_byte_wr    (sd_byte_wr),
		.sd_byte       (sd_byte),
		.sd_byte_addr  (sd_byte_addr),
		.sd_word_valid (sd_word_valid),
		.sd_word       (sd_word)
	);

endmodule

/* rtl/sd_word_packer.sv */
`timescale 1ns/1ns

module sd_word_packer (
	input  logic                       clk_1x,
	input  logic                       reset,
	input  logic [2:0]                 sd_ack,
	input  logic                       sd_byte_wr,
	input  logic [7:0]                 sd_byte,
	input  psx_loader_pkg::sd_baddr_t  sd_byte_addr,
	output logic                       sd_word_valid,
	output psx_loader_pkg::sd_word_t   sd_word
);

	logic [2:0] ack_q;
	logic       ack_rise;
	logic       hi_next;
	logic       hi_sel;
	logic [7:0] lo_byte;

	// New transfer on any channel restarts the byte pairing
	assign ack_rise = |(sd_ack & ~ack_q);
	assign hi_sel   = hi_next && !ack_rise;

	always_ff @(posedge clk_1x) begin
		if (reset) begin
			ack_q         <= 3'd0;
			hi_next       <= 1'b0;
			sd_word_valid <= 1'b0;
		end else begin
			ack_q         <= sd_ack;
			sd_word_valid <= sd_byte_wr && hi_sel;
			if (sd_byte_wr)
				hi_next <= !hi_sel;
			else if (ack_rise)
				hi_next <= 1'b0;
		end
	end

	// Low byte first, word goes out with the high byte
	always_ff @(posedge clk_1x) begin
		if (sd_byte_wr && !hi_sel)
			lo_byte <= sd_byte;
		if (sd_byte_wr && hi_sel) begin
			sd_word.addr <= sd_byte_addr[9:1];
			sd_word.data <= {sd_byte, lo_byte};
		end
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module psx_loader_tb \
	-f psx_loader.f -o psx_loader_sim

./obj_dir/psx_loader_sim | tee sim.log

if grep -q "^TEST OK$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi
